// File: include/stream_settings.svh
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// width of one stream element in bits.
`define STREAM_ELEM_WIDTH 8

// elements carried side by side in one beat.
`define STREAM_NUM_ELEMENTS 4

// filtered branches behind the fork; also the drop-mask width.
`define STREAM_NUM_BRANCHES 2

`endif

// File: hdl/stream_pkg.sv
`default_nettype none

`include "stream_settings.svh"

package stream_pkg;

    // one byte lane of a beat.
    typedef logic [`STREAM_ELEM_WIDTH-1:0] elem_t;

    // bit i set means the packet is discarded on branch i.
    typedef logic [`STREAM_NUM_BRANCHES-1:0] drop_mask_t;

    // index of a single branch.
    typedef logic [0:0] branch_id_t;

endpackage

`default_nettype wire

// File: hdl/ndata_if.sv
`timescale 1ns/100ps
`default_nettype none

// one beat of NUM_ELEMENTS lanes with per-lane keep and a packet end flag.
interface ndata_if #(
    parameter type data_t       = logic [7:0],
    parameter int  NUM_ELEMENTS = 4
);

    data_t [NUM_ELEMENTS-1:0] data;
    logic  [NUM_ELEMENTS-1:0] keep;
    logic                     last;
    logic                     valid;
    logic                     ready;

    // driving side.
    modport src (
        output data,
        output keep,
        output last,
        output valid,
        input  ready
    );

    // receiving side.
    modport snk (
        input  data,
        input  keep,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/stream_fork.sv
`timescale 1ns/100ps
`default_nettype none

module stream_fork (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    ndata_if.snk                        in,
    ndata_if.src                        out0,
    ndata_if.src                        out1,
    input  wire stream_pkg::drop_mask_t drop_mask,
    input  wire logic                   drop_mask_valid,
    output logic                        drop_mask_ready,
    output stream_pkg::drop_mask_t      mask_data,
    output logic [1:0]                  mask_valid,
    input  wire logic [1:0]             mask_ready
);

    // beat payload goes to both branches unchanged.
    assign out0.data = in.data;
    assign out0.keep = in.keep;
    assign out0.last = in.last;
    assign out1.data = in.data;
    assign out1.keep = in.keep;
    assign out1.last = in.last;

    // each branch only sees valid once the other side can take it too.
    assign out0.valid = in.valid && out1.ready;
    assign out1.valid = in.valid && out0.ready;
    assign in.ready   = out0.ready && out1.ready;

    // same rule for the mask stream.
    assign mask_data       = drop_mask;
    assign mask_valid[0]   = drop_mask_valid && mask_ready[1];
    assign mask_valid[1]   = drop_mask_valid && mask_ready[0];
    assign drop_mask_ready = &mask_ready;

    // a stalled input beat keeps its payload while it is still offered.
    assert property (@(posedge clk) disable iff (!rst_n)
        (in.valid && !in.ready) |=>
            (!in.valid || ($stable(in.data) && $stable(in.keep) && $stable(in.last))))
        else $error("input beat changed while waiting for both branches");

    // a stalled mask stays offered and unchanged until both branches take it.
    assert property (@(posedge clk) disable iff (!rst_n)
        (drop_mask_valid && !drop_mask_ready) |=> (drop_mask_valid && $stable(drop_mask)))
        else $error("drop mask changed while waiting for both branches");

endmodule

`default_nettype wire

// File: hdl/data_sink.sv
`timescale 1ns/100ps
`default_nettype none

module data_sink #(
    parameter int ID = 0
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire stream_pkg::drop_mask_t mask_data,
    input  wire logic                   mask_valid,
    output logic                        mask_ready,
    ndata_if.snk                        in,
    ndata_if.src                        out
);

    // drop decision for the packet in flight.
    logic drop_bit;
    // a mask is held for the current packet.
    logic held;

    logic mask_xfer;
    logic last_xfer;

    assign mask_xfer = mask_valid && mask_ready;
    assign last_xfer = in.valid && in.ready && in.last;

    // a new mask may replace the old one on the last beat of its packet.
    assign mask_ready = !held || last_xfer;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else if (mask_xfer) begin
            held <= 1'b1;
        end else if (last_xfer) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mask_xfer) begin
            drop_bit <= mask_data[ID];
        end
    end

    // dropped beats are swallowed one per cycle, whatever the output does.
    assign in.ready  = held && (drop_bit || out.ready);

    assign out.valid = in.valid && held && !drop_bit;
    assign out.data  = in.data;
    assign out.keep  = in.keep;
    assign out.last  = in.last;

    // the drop decision stays fixed from the mask until the last beat.
    assert property (@(posedge clk) disable iff (!rst_n)
        (held && !last_xfer) |=> (held && $stable(drop_bit)))
        else $error("branch %0d lost its drop decision inside a packet", ID);

endmodule

`default_nettype wire

// File: hdl/ndata_skid_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module ndata_skid_buffer #(
    parameter type data_t       = logic [7:0],
    parameter int  NUM_ELEMENTS = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    ndata_if.snk      in,
    ndata_if.src      out
);

    // main register feeds the output.
    data_t [NUM_ELEMENTS-1:0] main_data;
    logic  [NUM_ELEMENTS-1:0] main_keep;
    logic                     main_last;
    logic                     main_valid;

    // skid register catches the beat accepted while the output stalls.
    data_t [NUM_ELEMENTS-1:0] skid_data;
    logic  [NUM_ELEMENTS-1:0] skid_keep;
    logic                     skid_last;
    logic                     skid_valid;

    logic in_ready_q;
    logic in_xfer;
    logic out_xfer;

    logic main_load_in;
    logic main_load_skid;
    logic skid_load;
    logic main_valid_d;
    logic skid_valid_d;

    assign in_xfer  = in.valid && in_ready_q;
    assign out_xfer = main_valid && out.ready;

    always_comb begin
        main_load_in   = 1'b0;
        main_load_skid = 1'b0;
        skid_load      = 1'b0;
        main_valid_d   = main_valid;
        skid_valid_d   = skid_valid;
        if (!main_valid || out_xfer) begin
            // main is free next cycle; skid content goes first.
            if (skid_valid) begin
                main_load_skid = 1'b1;
                main_valid_d   = 1'b1;
                skid_valid_d   = 1'b0;
            end else begin
                main_load_in = in_xfer;
                main_valid_d = in_xfer;
            end
        end else if (in_xfer) begin
            skid_load    = 1'b1;
            skid_valid_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready_q <= 1'b1;
        end else begin
            main_valid <= main_valid_d;
            skid_valid <= skid_valid_d;
            in_ready_q <= !skid_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load_skid) begin
            main_data <= skid_data;
            main_keep <= skid_keep;
            main_last <= skid_last;
        end else if (main_load_in) begin
            main_data <= in.data;
            main_keep <= in.keep;
            main_last <= in.last;
        end
        if (skid_load) begin
            skid_data <= in.data;
            skid_keep <= in.keep;
            skid_last <= in.last;
        end
    end

    assign in.ready  = in_ready_q;
    assign out.valid = main_valid;
    assign out.data  = main_data;
    assign out.keep  = main_keep;
    assign out.last  = main_last;

    // a stalled beat stays put until taken.
    assert property (@(posedge clk) disable iff (!rst_n)
        (out.valid && !out.ready) |=>
            (out.valid && $stable(out.data) && $stable(out.keep) && $stable(out.last)))
        else $error("skid buffer output changed while stalled");

endmodule

`default_nettype wire

// File: hdl/packet_merge.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_settings.svh"

module packet_merge (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    ndata_if.snk                                              in0,
    ndata_if.snk                                              in1,
    output logic [`STREAM_NUM_ELEMENTS*`STREAM_ELEM_WIDTH-1:0] out_data,
    output logic [`STREAM_NUM_ELEMENTS-1:0]                   out_keep,
    output logic                                              out_last,
    output logic                                              out_valid,
    input  wire logic                                         out_ready,
    output stream_pkg::branch_id_t                            out_branch
);

    import stream_pkg::*;

    logic       locked;
    branch_id_t lock_sel;
    // branch tried first when unlocked.
    branch_id_t pref;
    branch_id_t sel;
    logic [1:0] in_valid;
    logic       last_xfer;

    assign in_valid = {in1.valid, in0.valid};

    // unlocked: preferred branch if it has a beat, else the other one.
    always_comb begin
        if (locked) begin
            sel = lock_sel;
        end else if (in_valid[pref]) begin
            sel = pref;
        end else begin
            sel = ~pref;
        end
    end

    assign out_valid  = in_valid[sel];
    assign out_data   = (sel == 1'b1) ? in1.data : in0.data;
    assign out_keep   = (sel == 1'b1) ? in1.keep : in0.keep;
    assign out_last   = (sel == 1'b1) ? in1.last : in0.last;
    assign out_branch = sel;

    assign in0.ready = out_ready && (sel == 1'b0);
    assign in1.ready = out_ready && (sel == 1'b1);

    assign last_xfer = out_valid && out_ready && out_last;

    // hold the grant from the first presented beat until the packet ends.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked   <= 1'b0;
            lock_sel <= '0;
            pref     <= '0;
        end else if (last_xfer) begin
            locked <= 1'b0;
            pref   <= ~sel;
        end else if (out_valid) begin
            locked   <= 1'b1;
            lock_sel <= sel;
        end
    end

    // packets from the two branches never interleave on the output.
    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !last_xfer) |=> (out_branch == $past(out_branch)))
        else $error("output branch changed inside a packet");

endmodule

`default_nettype wire

// File: hdl/filter_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_settings.svh"

module filter_top (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    input  wire logic [`STREAM_NUM_ELEMENTS*`STREAM_ELEM_WIDTH-1:0] in_data,
    input  wire logic [`STREAM_NUM_ELEMENTS-1:0]              in_keep,
    input  wire logic                                         in_last,
    input  wire logic                                         in_valid,
    output logic                                              in_ready,
    input  wire stream_pkg::drop_mask_t                       drop_mask,
    input  wire logic                                         drop_mask_valid,
    output logic                                              drop_mask_ready,
    output logic [`STREAM_NUM_ELEMENTS*`STREAM_ELEM_WIDTH-1:0] out_data,
    output logic [`STREAM_NUM_ELEMENTS-1:0]                   out_keep,
    output logic                                              out_last,
    output logic                                              out_valid,
    output stream_pkg::branch_id_t                            out_branch,
    input  wire logic                                         out_ready
);

    import stream_pkg::*;

    ndata_if #(.data_t(elem_t), .NUM_ELEMENTS(`STREAM_NUM_ELEMENTS)) fork_in ();
    ndata_if #(.data_t(elem_t), .NUM_ELEMENTS(`STREAM_NUM_ELEMENTS))
        br_in [`STREAM_NUM_BRANCHES] ();
    ndata_if #(.data_t(elem_t), .NUM_ELEMENTS(`STREAM_NUM_ELEMENTS))
        br_pass [`STREAM_NUM_BRANCHES] ();
    ndata_if #(.data_t(elem_t), .NUM_ELEMENTS(`STREAM_NUM_ELEMENTS))
        br_buf [`STREAM_NUM_BRANCHES] ();

    drop_mask_t                       mask_data;
    logic [`STREAM_NUM_BRANCHES-1:0] mask_valid;
    logic [`STREAM_NUM_BRANCHES-1:0] mask_ready;

    // flat input ports onto the beat bundle.
    assign fork_in.data  = in_data;
    assign fork_in.keep  = in_keep;
    assign fork_in.last  = in_last;
    assign fork_in.valid = in_valid;
    assign in_ready      = fork_in.ready;

    stream_fork u_fork (
        .clk             (clk),
        .rst_n           (rst_n),
        .in              (fork_in),
        .out0            (br_in[0]),
        .out1            (br_in[1]),
        .drop_mask       (drop_mask),
        .drop_mask_valid (drop_mask_valid),
        .drop_mask_ready (drop_mask_ready),
        .mask_data       (mask_data),
        .mask_valid      (mask_valid),
        .mask_ready      (mask_ready)
    );

    // per branch: filter, then a skid stage.
    for (genvar i = 0; i < `STREAM_NUM_BRANCHES; i++) begin : g_branch
        data_sink #(.ID(i)) u_sink (
            .clk        (clk),
            .rst_n      (rst_n),
            .mask_data  (mask_data),
            .mask_valid (mask_valid[i]),
            .mask_ready (mask_ready[i]),
            .in         (br_in[i]),
            .out        (br_pass[i])
        );

        ndata_skid_buffer #(
            .data_t       (elem_t),
            .NUM_ELEMENTS (`STREAM_NUM_ELEMENTS)
        ) u_skid (
            .clk   (clk),
            .rst_n (rst_n),
            .in    (br_pass[i]),
            .out   (br_buf[i])
        );
    end

    packet_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .in0        (br_buf[0]),
        .in1        (br_buf[1]),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_last   (out_last),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_branch (out_branch)
    );

endmodule

`default_nettype wire

// File: test/filter_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_settings.svh"

module filter_tb;

    import stream_pkg::*;

    localparam int BEAT_W      = `STREAM_NUM_ELEMENTS * `STREAM_ELEM_WIDTH;
    localparam int KEEP_W      = `STREAM_NUM_ELEMENTS;
    localparam int NUM_PKTS    = 12;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    // one table row per packet.
    typedef struct packed {
        logic [2:0]        beats;
        drop_mask_t        mask;
        elem_t             first;
        logic [KEEP_W-1:0] last_keep;
    } pkt_t;

    // expected output beat as {last, keep, data}.
    typedef logic [BEAT_W+KEEP_W:0] exp_beat_t;

    logic              clk;
    logic              rst_n;
    logic [BEAT_W-1:0] in_data;
    logic [KEEP_W-1:0] in_keep;
    logic              in_last;
    logic              in_valid;
    logic              in_ready;
    drop_mask_t        drop_mask;
    logic              drop_mask_valid;
    logic              drop_mask_ready;
    logic [BEAT_W-1:0] out_data;
    logic [KEEP_W-1:0] out_keep;
    logic              out_last;
    logic              out_valid;
    branch_id_t        out_branch;
    logic              out_ready;

    integer      seed = 32'h44c9_27ee;
    logic [31:0] rnd;

    exp_beat_t  exp_q0 [$];
    exp_beat_t  exp_q1 [$];
    exp_beat_t  exp_beat;
    logic       in_packet = 1'b0;
    branch_id_t pkt_branch = '0;

    // beats, drop mask, first byte, keep of the last beat.
    // a packet kept by both branches has at most two beats, the skid depth.
    pkt_t pkt_table [NUM_PKTS] = '{
        '{3'd2, 2'b00, 8'h10, 4'b1111},
        '{3'd1, 2'b00, 8'h20, 4'b0001},
        '{3'd3, 2'b01, 8'h30, 4'b0011},
        '{3'd4, 2'b10, 8'h40, 4'b0111},
        '{3'd2, 2'b11, 8'h50, 4'b1111},
        '{3'd2, 2'b00, 8'h60, 4'b0011},
        '{3'd3, 2'b01, 8'h70, 4'b1111},
        '{3'd1, 2'b10, 8'h80, 4'b0001},
        '{3'd4, 2'b11, 8'h90, 4'b0111},
        '{3'd2, 2'b00, 8'ha0, 4'b0001},
        '{3'd2, 2'b00, 8'hfa, 4'b1111},
        '{3'd1, 2'b01, 8'hc0, 4'b0011}
    };

    filter_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_data         (in_data),
        .in_keep         (in_keep),
        .in_last         (in_last),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .drop_mask       (drop_mask),
        .drop_mask_valid (drop_mask_valid),
        .drop_mask_ready (drop_mask_ready),
        .out_data        (out_data),
        .out_keep        (out_keep),
        .out_last        (out_last),
        .out_valid       (out_valid),
        .out_branch      (out_branch),
        .out_ready       (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_bit(input string name, input logic expected, input logic actual);
        assert (actual == expected) else
            fail_now($sformatf("FAIL %0t %s: expected %b, got %b",
                $time, name, expected, actual));
    endtask

    // bytes count up from the first one across lanes and beats.
    function automatic logic [BEAT_W-1:0] make_beat_data(input elem_t first, input int beat);
        logic [BEAT_W-1:0] d;
        for (int j = 0; j < KEEP_W; j++) begin
            d[j*`STREAM_ELEM_WIDTH +: `STREAM_ELEM_WIDTH] = first + elem_t'(KEEP_W * beat + j);
        end
        return d;
    endfunction

    task automatic queue_expected(input pkt_t pkt);
        exp_beat_t e;
        logic      is_last;
        for (int b = 0; b < int'(pkt.beats); b++) begin
            is_last = (b == int'(pkt.beats) - 1);
            e = {is_last, is_last ? pkt.last_keep : 4'hf, make_beat_data(pkt.first, b)};
            if (!pkt.mask[0]) begin
                exp_q0.push_back(e);
            end
            if (!pkt.mask[1]) begin
                exp_q1.push_back(e);
            end
        end
    endtask

    // both skid buffers must be empty before a packet kept by both branches.
    task automatic wait_outputs_idle();
        int cycles;
        cycles = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (exp_q0.size() == 0 && exp_q1.size() == 0) else
            fail_now("earlier packets did not leave the output before the timeout");
    endtask

    task automatic send_mask(input drop_mask_t mask);
        int cycles;
        cycles = 0;
        @(negedge clk);
        drop_mask       = mask;
        drop_mask_valid = 1'b1;
        @(posedge clk);
        while (!drop_mask_ready && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge clk);
        end
        assert (drop_mask_ready) else
            fail_now("drop mask was not accepted before the timeout");
        @(negedge clk);
        drop_mask_valid = 1'b0;
    endtask

    // leaves in_valid high; the caller lowers it after the packet.
    task automatic send_beat(input logic [BEAT_W-1:0] data, input logic [KEEP_W-1:0] keep,
                             input logic last);
        int cycles;
        cycles = 0;
        @(negedge clk);
        in_data  = data;
        in_keep  = keep;
        in_last  = last;
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge clk);
        end
        assert (in_ready) else
            fail_now("input beat was not accepted before the timeout");
    endtask

    task automatic check_beat(input exp_beat_t e);
        assert (out_data == e[BEAT_W-1:0]) else
            fail_now($sformatf("FAIL %0t out_data: expected %h, got %h",
                $time, e[BEAT_W-1:0], out_data));
        assert (out_keep == e[BEAT_W +: KEEP_W]) else
            fail_now($sformatf("FAIL %0t out_keep: expected %b, got %b",
                $time, e[BEAT_W +: KEEP_W], out_keep));
        expect_bit("out_last", e[BEAT_W+KEEP_W], out_last);
    endtask

    always @(negedge clk) begin
        rnd       = $random(seed);
        out_ready = rnd[0];
    end

    // output monitor, one scoreboard per branch.
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (in_packet) begin
                expect_bit("out_branch", pkt_branch, out_branch);
            end
            pkt_branch = out_branch;
            in_packet  = !out_last;
            if (out_branch == 1'b0) begin
                assert (exp_q0.size() > 0) else
                    fail_now("branch 0 delivered a beat that no packet expects");
                exp_beat = exp_q0.pop_front();
            end else begin
                assert (exp_q1.size() > 0) else
                    fail_now("branch 1 delivered a beat that no packet expects");
                exp_beat = exp_q1.pop_front();
            end
            check_beat(exp_beat);
        end
    end

    initial begin
        int cycles;
        rst_n           = 1'b0;
        in_data         = '0;
        in_keep         = '0;
        in_last         = 1'b0;
        in_valid        = 1'b0;
        drop_mask       = '0;
        drop_mask_valid = 1'b0;
        out_ready       = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(posedge clk);
        expect_bit("out_valid", 1'b0, out_valid);
        expect_bit("in_ready", 1'b0, in_ready);
        expect_bit("drop_mask_ready", 1'b1, drop_mask_ready);

        // no mask held, so the input must stall.
        @(negedge clk);
        in_data  = 32'hdead_beef;
        in_keep  = 4'hf;
        in_last  = 1'b1;
        in_valid = 1'b1;
        repeat (10) begin
            @(posedge clk);
            expect_bit("in_ready", 1'b0, in_ready);
            expect_bit("out_valid", 1'b0, out_valid);
        end
        @(negedge clk);
        in_valid = 1'b0;

        for (int p = 0; p < NUM_PKTS; p++) begin
            if (pkt_table[p].mask == 2'b00) begin
                wait_outputs_idle();
            end
            queue_expected(pkt_table[p]);
            send_mask(pkt_table[p].mask);
            for (int b = 0; b < int'(pkt_table[p].beats); b++) begin
                if (b == int'(pkt_table[p].beats) - 1) begin
                    send_beat(make_beat_data(pkt_table[p].first, b),
                        pkt_table[p].last_keep, 1'b1);
                end else begin
                    send_beat(make_beat_data(pkt_table[p].first, b), 4'hf, 1'b0);
                end
            end
            @(negedge clk);
            in_valid = 1'b0;
        end

        // skid buffers and merger empty out under back-pressure.
        cycles = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        // idle time to catch extra beats.
        repeat (10) @(negedge clk);
        if (exp_q0.size() == 0 && exp_q1.size() == 0 && !in_packet) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_now("branch queues did not drain before the timeout");
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hdl/stream_pkg.sv
hdl/ndata_if.sv
hdl/stream_fork.sv
hdl/data_sink.sv
hdl/ndata_skid_buffer.sv
hdl/packet_merge.sv
hdl/filter_top.sv
test/filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the filter testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module filter_tb -o filter_sim

# the simulator's own exit status is not used; the log decides.
./obj_dir/filter_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
